/* src/icache_pkg.sv */
package icache_pkg;

    // bus and fetch widths
    localparam int ADDR_W  = 32;
    localparam int BEAT_W  = 64;     // one R beat
    localparam int INSTR_W = 32;

    // direct-mapped geometry, 16 sets of 32-byte lines
    localparam int NUM_SETS = 16;
    localparam int BEATS    = 4;     // beats per line
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = 23;    // ADDR_W - INDEX_W - 5 offset bits

    // fetch address, seen as a bus word or split for the lookup
    typedef union packed {
        logic [ADDR_W-1:0] raw;      // bus address view
        struct packed {
            logic [TAG_W-1:0]   tag;
            logic [INDEX_W-1:0] index;
            logic [1:0]         beat;      // beat within the line
            logic               word;      // upper or lower half of the beat
            logic [1:0]         byte_off;  // must be zero for a fetch
        } f;
    } fetch_addr_u;

    // R channel response codes
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

/* src/icache_req_decode.sv */
module icache_req_decode (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 fetch_valid_i,
    input  logic [icache_pkg::ADDR_W-1:0]        fetch_addr_i,
    output logic                                 fetch_ready_o,
    output logic                                 req_valid_o,
    output icache_pkg::fetch_addr_u              req_addr_o,
    output logic                                 req_misaligned_o,
    input  logic                                 req_take_i
);

    logic                    full_q;       // one request held
    logic                    alive_q;      // first cycle after reset passed
    logic                    accept;
    icache_pkg::fetch_addr_u addr_d;

    assign addr_d.raw = fetch_addr_i;

    // room when empty, or when the held entry leaves this cycle
    assign fetch_ready_o = alive_q && (!full_q || req_take_i);
    assign accept        = fetch_valid_i && fetch_ready_o;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            full_q  <= 1'b0;
            alive_q <= 1'b0;
        end else begin
            alive_q <= 1'b1;
            if (accept)
                full_q <= 1'b1;
            else if (req_take_i)
                full_q <= 1'b0;    // taken, nothing new
        end
    end

    // payload, no reset needed
    always_ff @(posedge clock) begin
        if (accept) begin
            req_addr_o       <= addr_d;
            req_misaligned_o <= |addr_d.f.byte_off;   // not word aligned
        end
    end

    assign req_valid_o = full_q;

endmodule

/* src/icache_line_store.sv */
module icache_line_store (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic                                          flush_i,
    input  logic [icache_pkg::INDEX_W-1:0]                rd_index_i,
    output logic                                          rd_valid_o,
    output logic [icache_pkg::TAG_W-1:0]                  rd_tag_o,
    output logic [icache_pkg::BEATS-1:0][icache_pkg::BEAT_W-1:0] rd_data_o,
    input  logic                                          wr_en_i,
    input  logic [icache_pkg::INDEX_W-1:0]                wr_index_i,
    input  logic [$clog2(icache_pkg::BEATS)-1:0]          wr_beat_i,
    input  logic [icache_pkg::BEAT_W-1:0]                 wr_data_i,
    input  logic [icache_pkg::TAG_W-1:0]                  wr_tag_i,
    input  logic                                          set_valid_i
);

    logic [icache_pkg::NUM_SETS-1:0] valid_q;
    logic [icache_pkg::TAG_W-1:0]    tag_q  [icache_pkg::NUM_SETS];
    logic [icache_pkg::BEATS-1:0][icache_pkg::BEAT_W-1:0] data_q [icache_pkg::NUM_SETS];

    // valid bits
    // set_valid comes with the last beat, so it wins over the beat write
    always_ff @(posedge clock or negedge reset) begin
        if (!reset)
            valid_q <= '0;
        else if (flush_i)
            valid_q <= '0;                    // fence.i
        else if (set_valid_i)
            valid_q[wr_index_i] <= 1'b1;
        else if (wr_en_i)
            valid_q[wr_index_i] <= 1'b0;      // line half written
    end

    // tag and data arrays
    always_ff @(posedge clock) begin
        if (wr_en_i)
            data_q[wr_index_i][wr_beat_i] <= wr_data_i;
        if (set_valid_i)
            tag_q[wr_index_i] <= wr_tag_i;
    end

    // combinational read of the whole set
    assign rd_valid_o = valid_q[rd_index_i];
    assign rd_tag_o   = tag_q[rd_index_i];
    assign rd_data_o  = data_q[rd_index_i];

endmodule

/* src/icache_refill_axi.sv */
module icache_refill_axi (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 start_i,
    input  logic [icache_pkg::ADDR_W-1:0]        line_addr_i,
    output logic                                 busy_o,
    output logic                                 ar_valid_o,
    input  logic                                 ar_ready_i,
    output logic [icache_pkg::ADDR_W-1:0]        ar_addr_o,
    input  logic                                 r_valid_i,
    output logic                                 r_ready_o,
    input  logic [icache_pkg::BEAT_W-1:0]        r_data_i,
    input  logic [1:0]                           r_resp_i,
    input  logic                                 r_last_i,
    output logic                                 beat_valid_o,
    output logic [$clog2(icache_pkg::BEATS)-1:0] beat_num_o,
    output logic [icache_pkg::BEAT_W-1:0]        beat_data_o,
    output logic                                 done_o,
    output logic                                 error_o
);

    localparam logic [1:0] ST_IDLE    = 2'b00;
    localparam logic [1:0] ST_AR_WAIT = 2'b01;
    localparam logic [1:0] ST_R_WAIT  = 2'b11;

    logic [1:0]                           state_q;
    logic [1:0]                           state_d;
    logic [icache_pkg::ADDR_W-1:0]        addr_q;
    logic [$clog2(icache_pkg::BEATS)-1:0] cnt_q;    // beat counter
    logic                                 err_q;    // sticky over the burst

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:    if (start_i) state_d = ST_AR_WAIT;
            ST_AR_WAIT: if (ar_ready_i) state_d = ST_R_WAIT;
            ST_R_WAIT:  if (done_o) state_d = ST_IDLE;
            default:    state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (start_i && state_q == ST_IDLE) begin
                cnt_q <= '0;
                err_q <= 1'b0;
            end else if (beat_valid_o) begin
                cnt_q <= cnt_q + 1'b1;
                err_q <= error_o;
            end
        end
    end

    // line base, held for the whole burst
    always_ff @(posedge clock) begin
        if (start_i && state_q == ST_IDLE)
            addr_q <= line_addr_i;
    end

    assign ar_valid_o = state_q == ST_AR_WAIT;
    assign ar_addr_o  = addr_q;
    assign r_ready_o  = state_q == ST_R_WAIT;   // only while waiting for data
    assign busy_o     = state_q != ST_IDLE;

    // beat report towards the controller
    assign beat_valid_o = r_valid_i && r_ready_o;
    assign beat_num_o   = cnt_q;
    assign beat_data_o  = r_data_i;
    assign done_o       = beat_valid_o && r_last_i;
    assign error_o      = err_q || (beat_valid_o && r_resp_i != icache_pkg::AXI_RESP_OKAY);

endmodule

/* src/icache_ctrl.sv */
module icache_ctrl (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 flush_i,
    input  logic                                 req_valid_i,
    input  icache_pkg::fetch_addr_u              req_addr_i,
    input  logic                                 req_misaligned_i,
    output logic                                 req_take_o,
    output logic                                 store_flush_o,
    output logic [icache_pkg::INDEX_W-1:0]       store_index_o,
    input  logic                                 store_rd_valid_i,
    input  logic [icache_pkg::TAG_W-1:0]         store_rd_tag_i,
    input  logic [icache_pkg::BEATS-1:0][icache_pkg::BEAT_W-1:0] store_rd_data_i,
    output logic                                 store_wr_en_o,
    output logic [$clog2(icache_pkg::BEATS)-1:0] store_wr_beat_o,
    output logic [icache_pkg::BEAT_W-1:0]        store_wr_data_o,
    output logic [icache_pkg::TAG_W-1:0]         store_wr_tag_o,
    output logic                                 store_set_valid_o,
    output logic                                 refill_start_o,
    output logic [icache_pkg::ADDR_W-1:0]        refill_addr_o,
    input  logic                                 refill_busy_i,
    input  logic                                 beat_valid_i,
    input  logic [$clog2(icache_pkg::BEATS)-1:0] beat_num_i,
    input  logic [icache_pkg::BEAT_W-1:0]        beat_data_i,
    input  logic                                 refill_done_i,
    input  logic                                 refill_error_i,
    output logic                                 resp_load_o,
    output logic [icache_pkg::BEAT_W-1:0]        resp_beat_o,
    output logic                                 resp_word_o,
    output logic                                 resp_error_o,
    input  logic                                 resp_busy_i
);

    localparam logic [1:0] S_IDLE   = 2'b00;
    localparam logic [1:0] S_LOOKUP = 2'b01;
    localparam logic [1:0] S_REFILL = 2'b11;
    localparam logic [1:0] S_RESP   = 2'b10;   // deliver the refilled beat

    logic [1:0]              state_q;
    logic                    flush_pend_q;
    icache_pkg::fetch_addr_u addr_q;          // request under work
    icache_pkg::fetch_addr_u line_base;
    logic                    mis_q;
    logic                    err_q;
    logic [icache_pkg::BEAT_W-1:0] want_q;    // wanted beat seen in the burst
    logic                    hit;
    logic                    lookup_done;

    assign hit         = store_rd_valid_i && store_rd_tag_i == addr_q.f.tag;
    assign req_take_o  = state_q == S_IDLE && req_valid_i && !resp_busy_i;
    assign lookup_done = state_q == S_LOOKUP && !resp_busy_i && (mis_q || hit);

    always_comb begin
        line_base            = addr_q;
        line_base.f.beat     = '0;
        line_base.f.word     = 1'b0;
        line_base.f.byte_off = '0;
    end

    // refill launch, no fetch for a misaligned request
    assign refill_start_o = state_q == S_LOOKUP && !mis_q && !hit;
    assign refill_addr_o  = line_base.raw;

    // line store writes follow the R beats
    assign store_index_o     = addr_q.f.index;
    assign store_wr_en_o     = beat_valid_i;
    assign store_wr_beat_o   = beat_num_i;
    assign store_wr_data_o   = beat_data_i;
    assign store_wr_tag_o    = addr_q.f.tag;
    assign store_set_valid_o = refill_done_i && !refill_error_i;   // bad line stays invalid
    assign store_flush_o     = (flush_i || flush_pend_q) && !refill_busy_i;

    assign resp_load_o  = lookup_done || (state_q == S_RESP && !resp_busy_i);
    assign resp_beat_o  = state_q == S_RESP ? want_q : store_rd_data_i[addr_q.f.beat];
    assign resp_word_o  = addr_q.f.word;
    assign resp_error_o = state_q == S_RESP ? err_q : mis_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q      <= S_IDLE;
            flush_pend_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE:   if (req_take_o) state_q <= S_LOOKUP;
                S_LOOKUP: begin
                    if (lookup_done)
                        state_q <= S_IDLE;
                    else if (refill_start_o)
                        state_q <= S_REFILL;
                end
                S_REFILL: if (refill_done_i) state_q <= S_RESP;
                default:  if (!resp_busy_i) state_q <= S_IDLE;
            endcase
            flush_pend_q <= (flush_i || flush_pend_q) && !store_flush_o;  // held over a refill
        end
    end

    always_ff @(posedge clock) begin
        if (req_take_o) begin
            addr_q <= req_addr_i;
            mis_q  <= req_misaligned_i;
        end
        if (beat_valid_i && beat_num_i == addr_q.f.beat)
            want_q <= beat_data_i;
        if (refill_done_i)
            err_q <= refill_error_i;
    end

endmodule

/* src/icache_resp.sv */
module icache_resp (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           load_i,
    input  logic [icache_pkg::BEAT_W-1:0]  beat_i,
    input  logic                           word_i,
    input  logic                           error_i,
    output logic                           busy_o,
    output logic                           resp_valid_o,
    input  logic                           resp_ready_i,
    output logic [icache_pkg::INSTR_W-1:0] resp_instr_o,
    output logic                           resp_error_o
);

    logic [icache_pkg::INSTR_W-1:0] half;

    // pick the 32-bit half, zero on error
    always_comb begin
        half = word_i ? beat_i[icache_pkg::BEAT_W-1:icache_pkg::INSTR_W]
                      : beat_i[icache_pkg::INSTR_W-1:0];
        if (error_i)
            half = '0;
    end

    // a held response frees up in the cycle it is taken
    assign busy_o = resp_valid_o && !resp_ready_i;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset)
            resp_valid_o <= 1'b0;
        else if (load_i)
            resp_valid_o <= 1'b1;
        else if (resp_ready_i)
            resp_valid_o <= 1'b0;   // handshake done
    end

    always_ff @(posedge clock) begin
        if (load_i) begin
            resp_instr_o <= half;
            resp_error_o <= error_i;
        end
    end

endmodule

/* src/icache_top.sv */
module icache_top (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           flush_i,
    input  logic                           fetch_valid_i,
    input  logic [icache_pkg::ADDR_W-1:0]  fetch_addr_i,
    output logic                           fetch_ready_o,
    output logic                           resp_valid_o,
    input  logic                           resp_ready_i,
    output logic [icache_pkg::INSTR_W-1:0] resp_instr_o,
    output logic                           resp_error_o,
    output logic                           ar_valid_o,
    input  logic                           ar_ready_i,
    output logic [icache_pkg::ADDR_W-1:0]  ar_addr_o,
    input  logic                           r_valid_i,
    output logic                           r_ready_o,
    input  logic [icache_pkg::BEAT_W-1:0]  r_data_i,
    input  logic [1:0]                     r_resp_i,
    input  logic                           r_last_i
);

    // decode to ctrl
    logic                    req_valid, req_mis, req_take;
    icache_pkg::fetch_addr_u req_addr;

    // ctrl to line store
    logic                                 st_flush, st_rd_valid, st_wr_en, st_set_valid;
    logic [icache_pkg::INDEX_W-1:0]       st_index;
    logic [icache_pkg::TAG_W-1:0]         st_rd_tag, st_wr_tag;
    logic [icache_pkg::BEATS-1:0][icache_pkg::BEAT_W-1:0] st_rd_data;
    logic [$clog2(icache_pkg::BEATS)-1:0] st_wr_beat;
    logic [icache_pkg::BEAT_W-1:0]        st_wr_data;

    // ctrl and refill master
    logic                                 rf_start, rf_busy, rf_beat, rf_done, rf_err;
    logic [icache_pkg::ADDR_W-1:0]        rf_addr;
    logic [$clog2(icache_pkg::BEATS)-1:0] rf_num;
    logic [icache_pkg::BEAT_W-1:0]        rf_data;

    // ctrl to response stage
    logic                          rs_load, rs_word, rs_err, rs_busy;
    logic [icache_pkg::BEAT_W-1:0] rs_beat;

    icache_req_decode req_decode_i (
        .clock, .reset, .fetch_valid_i, .fetch_addr_i, .fetch_ready_o,
        .req_valid_o(req_valid), .req_addr_o(req_addr), .req_misaligned_o(req_mis),
        .req_take_i(req_take));

    icache_line_store line_store_i (
        .clock, .reset, .flush_i(st_flush), .rd_index_i(st_index),
        .rd_valid_o(st_rd_valid), .rd_tag_o(st_rd_tag), .rd_data_o(st_rd_data),
        .wr_en_i(st_wr_en), .wr_index_i(st_index), .wr_beat_i(st_wr_beat),
        .wr_data_i(st_wr_data), .wr_tag_i(st_wr_tag), .set_valid_i(st_set_valid));

    icache_refill_axi refill_i (
        .clock, .reset, .start_i(rf_start), .line_addr_i(rf_addr), .busy_o(rf_busy),
        .ar_valid_o, .ar_ready_i, .ar_addr_o, .r_valid_i, .r_ready_o, .r_data_i,
        .r_resp_i, .r_last_i, .beat_valid_o(rf_beat), .beat_num_o(rf_num),
        .beat_data_o(rf_data), .done_o(rf_done), .error_o(rf_err));

    icache_ctrl ctrl_i (
        .clock, .reset, .flush_i, .req_valid_i(req_valid), .req_addr_i(req_addr),
        .req_misaligned_i(req_mis), .req_take_o(req_take), .store_flush_o(st_flush),
        .store_index_o(st_index), .store_rd_valid_i(st_rd_valid), .store_rd_tag_i(st_rd_tag),
        .store_rd_data_i(st_rd_data), .store_wr_en_o(st_wr_en), .store_wr_beat_o(st_wr_beat),
        .store_wr_data_o(st_wr_data), .store_wr_tag_o(st_wr_tag),
        .store_set_valid_o(st_set_valid), .refill_start_o(rf_start), .refill_addr_o(rf_addr),
        .refill_busy_i(rf_busy), .beat_valid_i(rf_beat), .beat_num_i(rf_num),
        .beat_data_i(rf_data), .refill_done_i(rf_done), .refill_error_i(rf_err),
        .resp_load_o(rs_load), .resp_beat_o(rs_beat), .resp_word_o(rs_word),
        .resp_error_o(rs_err), .resp_busy_i(rs_busy));

    icache_resp resp_i (
        .clock, .reset, .load_i(rs_load), .beat_i(rs_beat), .word_i(rs_word),
        .error_i(rs_err), .busy_o(rs_busy), .resp_valid_o, .resp_ready_i,
        .resp_instr_o, .resp_error_o);

endmodule

/* dv/axi_mem_model.sv */
module axi_mem_model (
    input  logic        clock,
    input  logic        reset,
    input  logic        ar_valid_i,
    output logic        ar_ready_o,
    input  logic [31:0] ar_addr_i,
    output logic        r_valid_o,
    input  logic        r_ready_i,
    output logic [63:0] r_data_o,
    output logic [1:0]  r_resp_o,
    output logic        r_last_o,
    output int          ar_count_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;   // whole upper half of the map

    logic        busy;      // burst in progress
    logic        hold;      // beat shown but not taken yet
    logic [31:0] base;      // line base of the burst
    int          beat;

    // data of one 8-byte beat, a fixed function of its address
    function automatic logic [63:0] beat_value(input logic [31:0] a);
        return ({32'h0, a} * 64'h9e37_79b9_7f4a_7c15) ^ {~a, 32'h0};
    endfunction

    initial begin
        busy       = 1'b0;
        hold       = 1'b0;
        base       = '0;
        beat       = 0;
        ar_count_o = 0;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_data_o   = '0;
        r_resp_o   = RESP_OKAY;
        r_last_o   = 1'b0;
    end

    always @(posedge clock) begin
        hold = 1'b0;
        if (!reset) begin
            busy = 1'b0;
        end else if (busy && r_valid_o && r_ready_i) begin
            beat = beat + 1;
            busy = beat < 4;            // four beats, INCR
        end else if (busy) begin
            hold = r_valid_o;           // keep a pending beat
        end else if (ar_valid_i && ar_ready_o) begin
            busy       = 1'b1;
            base       = ar_addr_i;
            beat       = 0;
            ar_count_o = ar_count_o + 1;
        end
        #1;
        // random stalls on both channels
        ar_ready_o = reset && !busy && ($urandom_range(0, 3) != 0);
        r_valid_o  = busy && (hold || $urandom_range(0, 2) != 0);
        r_data_o   = beat_value(base + 32'(beat) * 32'd8);
        r_resp_o   = base[31] ? RESP_SLVERR : RESP_OKAY;
        r_last_o   = beat == 3;
    end

endmodule

/* dv/icache_tb.sv */
module icache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_RAND  = 120;
    localparam int N_MIS   = 8;
    localparam int N_BP    = 100;
    localparam int N_TOTAL = N_RAND + 3 + N_MIS + 2 + 16 + N_BP;   // most fetches of a run

    // line bases with sets 0 and 1 aliased by a second tag
    localparam logic [31:0] LINES [6] = '{32'h0000_1000, 32'h0000_1020, 32'h0000_3000,
                                          32'h0000_21e0, 32'h0004_0020, 32'h0000_10c0};

    logic        clock;
    logic        reset;
    logic        flush;
    logic        fetch_valid;
    logic        fetch_ready;
    logic [31:0] fetch_addr;
    logic        resp_valid;
    logic        resp_ready;
    logic        resp_error;
    logic [31:0] resp_instr;
    logic        ar_valid, ar_ready, r_valid, r_ready, r_last;
    logic [31:0] ar_addr;
    logic [63:0] r_data;
    logic [1:0]  r_resp;
    int          ar_count;

    // reference model state
    logic        line_valid [16];
    logic [22:0] line_tag   [16];
    logic [31:0] exp_instr  [$];
    logic        exp_error  [$];
    logic [31:0] exp_ar_addr [$];      // line bases of the predicted misses
    logic [31:0] flush_lines [$];
    int          exp_ar = 0;
    int          ar_before;
    int          errors = 0;
    int          n_sent = 0;
    string       test_name = "reset";
    logic        backpressure = 1'b0;
    logic        held;                 // response stalled at the last edge
    logic [31:0] held_instr;
    logic        held_error;

    icache_top dut_i (
        .clock, .reset, .flush_i(flush), .fetch_valid_i(fetch_valid),
        .fetch_addr_i(fetch_addr), .fetch_ready_o(fetch_ready), .resp_valid_o(resp_valid),
        .resp_ready_i(resp_ready), .resp_instr_o(resp_instr), .resp_error_o(resp_error),
        .ar_valid_o(ar_valid), .ar_ready_i(ar_ready), .ar_addr_o(ar_addr),
        .r_valid_i(r_valid), .r_ready_o(r_ready), .r_data_i(r_data), .r_resp_i(r_resp),
        .r_last_i(r_last));

    axi_mem_model mem_i (
        .clock, .reset, .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_addr_i(ar_addr),
        .r_valid_o(r_valid), .r_ready_i(r_ready), .r_data_o(r_data), .r_resp_o(r_resp),
        .r_last_o(r_last), .ar_count_o(ar_count));

    // instruction word that memory holds at a word address
    function automatic logic [31:0] expected_word(input logic [31:0] a);
        logic [31:0] b;
        logic [63:0] d;
        b = a & ~32'h7;
        d = ({32'h0, b} * 64'h9e37_79b9_7f4a_7c15) ^ {~b, 32'h0};
        return a[2] ? d[63:32] : d[31:0];
    endfunction

    // direct-mapped lookup in request order
    function automatic void predict(input logic [31:0] a);
        logic [3:0]  idx;
        logic        err;
        idx = a[8:5];
        if (a[1:0] != 2'b00) begin
            err = 1'b1;                          // misaligned so no bus access
        end else if (line_valid[idx] && line_tag[idx] == a[31:9]) begin
            err = 1'b0;
        end else begin
            exp_ar++;
            exp_ar_addr.push_back(a & ~32'h1f);  // refill starts at the line base
            err = a[31];                         // error region never validates
            line_valid[idx] = !err;              // beat writes drop the old line
            line_tag[idx]   = a[31:9];
        end
        exp_instr.push_back(err ? 32'h0 : expected_word(a));
        exp_error.push_back(err);
    endfunction

    function automatic logic [31:0] random_addr();
        return LINES[3'($urandom_range(0, 5))] + (32'($urandom_range(0, 7)) << 2);
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s %s expected %0h actual %0h", test_name, name, expected, actual);
            errors++;
        end
    endtask

    // one fetch handshake entered and left 1 ns after an edge
    task automatic send_fetch(input logic [31:0] a);
        if ($urandom_range(0, 3) == 0) begin
            @(posedge clock);
            #1;
        end
        predict(a);
        fetch_valid = 1'b1;
        fetch_addr  = a;
        do @(posedge clock); while (!fetch_ready);
        #1;
        fetch_valid = 1'b0;
        n_sent++;
    endtask

    task automatic drain();
        do @(posedge clock); while (exp_instr.size() != 0);
        repeat (2) @(posedge clock);
        #1;
        check_value("ar_count", 64'(exp_ar), 64'(ar_count));
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // response ready is random only in the back-pressure test
    initial begin
        resp_ready = 1'b1;
        forever begin
            @(posedge clock);
            #1;
            resp_ready = !backpressure || ($urandom_range(0, 2) != 0);
        end
    end

    // in-order response checker plus hold under back-pressure
    initial begin
        held = 1'b0;
        forever begin
            @(posedge clock);
            if (held) begin
                check_value("hold_valid", 64'(1'b1), 64'(resp_valid));
                check_value("hold_instr", 64'(held_instr), 64'(resp_instr));
                check_value("hold_error", 64'(held_error), 64'(resp_error));
            end
            if (reset && resp_valid && resp_ready) begin
                if (exp_instr.size() == 0) begin
                    $display("%s: a response came with no fetch outstanding", test_name);
                    errors++;
                end else begin
                    check_value("resp_instr", 64'(exp_instr[0]), 64'(resp_instr));
                    check_value("resp_error", 64'(exp_error[0]), 64'(resp_error));
                    void'(exp_instr.pop_front());
                    void'(exp_error.pop_front());
                end
            end
            held       = reset && resp_valid && !resp_ready;
            held_instr = resp_instr;
            held_error = resp_error;
        end
    end

    // each accepted AR carries the base of the next predicted miss
    initial begin
        forever begin
            @(posedge clock);
            if (reset && ar_valid && ar_ready) begin
                if (exp_ar_addr.size() == 0) begin
                    $display("%s: an AR request came with no miss outstanding", test_name);
                    errors++;
                end else begin
                    check_value("ar_addr", 64'(exp_ar_addr[0]), 64'(ar_addr));
                    void'(exp_ar_addr.pop_front());
                end
            end
        end
    end

    initial begin
        repeat (N_TOTAL * 200) @(posedge clock);
        $display("timeout: the cache stopped answering fetches during %s", test_name);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h62e9_fb50));
        reset       = 1'b0;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        for (int s = 0; s < 16; s++)
            line_valid[s[3:0]] = 1'b0;
        repeat (4) @(posedge clock);
        // handshake outputs stay low while reset is held
        check_value("reset_fetch_ready", 64'(1'b0), 64'(fetch_ready));
        check_value("reset_resp_valid", 64'(1'b0), 64'(resp_valid));
        check_value("reset_ar_valid", 64'(1'b0), 64'(ar_valid));
        check_value("reset_r_ready", 64'(1'b0), 64'(r_ready));
        #1;
        reset = 1'b1;
        @(posedge clock);
        #1;
        check_value("ready_after_reset", 64'(1'b1), 64'(fetch_ready));

        test_name = "random_fetch";
        repeat (N_RAND) send_fetch(random_addr());
        drain();

        test_name = "line_reuse";                // one AR for three words of a line
        ar_before = ar_count;
        send_fetch(32'h0000_5a40);
        send_fetch(32'h0000_5a44);
        send_fetch(32'h0000_5a58);
        drain();
        check_value("reuse_ar", 64'(ar_before + 1), 64'(ar_count));

        test_name = "misaligned";
        ar_before = ar_count;
        repeat (N_MIS) send_fetch(random_addr() | 32'($urandom_range(1, 3)));
        drain();
        check_value("misaligned_ar", 64'(ar_before), 64'(ar_count));

        test_name = "error_region";              // line stays invalid so the refetch goes out
        ar_before = ar_count;
        send_fetch(32'h8000_0140);
        send_fetch(32'h8000_0148);
        drain();
        check_value("error_refetch_ar", 64'(ar_before + 2), 64'(ar_count));

        test_name = "flush";
        flush_lines.delete();
        for (int s = 0; s < 16; s++)
            if (line_valid[s[3:0]])
                flush_lines.push_back({line_tag[s[3:0]], s[3:0], 5'b0});
        flush = 1'b1;
        @(posedge clock);
        #1;
        flush = 1'b0;
        for (int s = 0; s < 16; s++)
            line_valid[s[3:0]] = 1'b0;
        ar_before = ar_count;
        foreach (flush_lines[i])
            send_fetch(flush_lines[i]);
        drain();
        check_value("flush_refills", 64'(ar_before + flush_lines.size()), 64'(ar_count));

        test_name = "backpressure";
        backpressure = 1'b1;
        repeat (N_BP) send_fetch(random_addr());
        drain();
        backpressure = 1'b0;

        $display("fetches: %0d  errors: %0d", n_sent, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* sources.f */
src/icache_pkg.sv
src/icache_req_decode.sv
src/icache_line_store.sv
src/icache_refill_axi.sv
src/icache_ctrl.sv
src/icache_resp.sv
src/icache_top.sv
dv/axi_mem_model.sv
dv/icache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the instruction cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f sources.f \
    --top-module icache_tb -o icache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/icache_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TEST RESULT: PASS$"; then
    exit 0
fi
exit 1
